// ==== vlog.f ====
common/pad_pkg.sv
pad/port_sequencer.sv
pad/mouse_tracker.sv
pad/nibble_mux.sv
verilog/pad_port_top.sv
sim/pad_port_assert.sv
sim/pad_port_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := pad_port_tb
RTL_TOP   := pad_port_top
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
LINTFLAGS := --lint-only -Wall --timing --assert --timescale 1ns/100ps
RUNFLAGS  := +verilator+error+limit+100
PASS_MSG  := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only if the testbench printed the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/pad_port_tb.sv ====
/*
  Testbench for the controller port.
  Inputs change 0.5 ns after a rising edge. joy_in is checked at the falling
  edge against a cycle model, once the inputs have held for three cycles.
  The idle test runs past the 32767-cycle mouse timeout.
*/
`default_nettype none

module pad_port_tb import pad_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HOLD        = 5;
	localparam int IDLE_LEN    = 32767;
	// Short tests need well under 2000 cycles, the idle test dominates
	localparam int TEST_CYCLES = IDLE_LEN + 2000;
	localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

	logic   clk_sys;
	logic   reset;
	pad_t   pad_a, pad_b, pad_c, pad_d, pad_e;
	logic   joy_swap, turbotap, buttons6, mouse_en;
	logic   mouse_strobe, mouse_lbtn, mouse_rbtn, sel, clr;
	delta_t mouse_dx, mouse_dy;
	nibble_t joy_in;

	// Cycle model of the port
	port_t        m_port;
	logic         m_bank;
	mouse_phase_t m_phase;
	delta_t       m_acc_x, m_acc_y, m_snap_x, m_snap_y;
	logic [14:0]  m_idle;
	logic         m_sel_d, m_clr_d;
	nibble_t      exp_joy;

	logic [85:0] in_now;
	logic [85:0] in_prev = '0;
	logic [15:0] lfsr;
	int stable_cnt = 0;
	int cycle_cnt = 0;
	int err_cnt = 0;
	int chk_cnt = 0;
	int assert_fails;

	pad_port_top u_pad_port_top (.*);

	assign in_now = {reset, pad_a, pad_b, pad_c, pad_d, pad_e, joy_swap, turbotap,
		buttons6, mouse_en, mouse_strobe, mouse_dx, mouse_dy, mouse_lbtn, mouse_rbtn, sel, clr};

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// Expected nibble from the modelled state and the current inputs
	function automatic nibble_t ref_nibble();
		pad_t    pw;
		int      idx;
		nibble_t pos;
		idx = 2 * m_bank + sel;
		case (m_port)
			3'd0: pw = joy_swap ? pad_b : pad_a;
			3'd1: pw = joy_swap ? pad_a : pad_b;
			3'd2: pw = pad_c;
			3'd3: pw = pad_d;
			3'd4: pw = pad_e;
			default: return (idx == 3) ? 4'h0 : 4'hF;
		endcase
		case (m_phase)
			X_HIGH:  pos = m_snap_x[7:4];
			X_LOW:   pos = m_snap_x[3:0];
			Y_HIGH:  pos = m_snap_y[7:4];
			default: pos = m_snap_y[3:0];
		endcase
		if (m_port == 3'd0 && mouse_en) begin
			return idx[0] ? pos : ~{pw[7], pw[6], mouse_lbtn, mouse_rbtn};
		end
		// Bits are right, left, down, up, I, II, select, run, III to VI
		case (idx)
			0:       return ~{pw[7], pw[6], pw[5], pw[4]};
			1:       return ~{pw[1], pw[2], pw[0], pw[3]};
			2:       return ~pw[11:8];
			default: return 4'h0;
		endcase
	endfunction

	// ====================
	// Model update
	// ====================
	always @(posedge clk_sys) begin
		cycle_cnt++;
		stable_cnt = (in_now == in_prev) ? stable_cnt + 1 : 0;
		in_prev = in_now;
		if (reset) begin
			m_port   = '0;
			m_bank   = 1'b0;
			m_phase  = Y_LOW;
			m_acc_x  = '0;
			m_acc_y  = '0;
			m_snap_x = '0;
			m_snap_y = '0;
			m_idle   = '0;
			m_sel_d  = 1'b0;
			m_clr_d  = 1'b0;
			exp_joy  = '0;
		end else begin
			exp_joy = clr ? 4'h0 : ref_nibble();
			if (clr && !m_clr_d) begin
				if (m_phase == Y_LOW) begin
					m_snap_x = m_acc_x;
					m_snap_y = m_acc_y;
					m_acc_x  = '0;
					m_acc_y  = '0;
				end
				m_phase = mouse_phase_t'(m_phase + 2'd1);
				m_bank  = buttons6 & ~m_bank;
			end else if (m_idle == 15'h7FFF) begin
				m_phase = Y_LOW;
			end
			if (mouse_strobe) begin
				m_acc_x = 8'd0 - mouse_dx;
				m_acc_y = mouse_dy;
			end
			if (clr) begin
				m_port = '0;
				m_idle = '0;
			end else begin
				if (sel && !m_sel_d && turbotap) begin
					m_port = m_port + 3'd1;
				end
				if (m_idle != 15'h7FFF) begin
					m_idle = m_idle + 15'd1;
				end
			end
			m_sel_d = sel;
			m_clr_d = clr;
		end
	end

	always @(negedge clk_sys) begin
		if (!reset && stable_cnt >= 3) begin
			check_nibble("joy_in", exp_joy, joy_in);
		end
	end

	task automatic check_nibble(input string name, input nibble_t exp, input nibble_t act);
		chk_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("ERR %0t %s: expected %h, actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_port(input string name, input port_t exp, input port_t act);
		chk_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("ERR %0t %s: expected %0d, actual %0d", $time, name, exp, act);
		end
	endtask

	// ====================
	// Stimulus helpers
	// ====================
	task automatic tick(input int n);
		repeat (n) @(posedge clk_sys);
		#0.5;
	endtask

	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[14:0], lfsr[0]};
		end
	endtask

	task automatic new_pads();
		logic [15:0] v;
		take_bits(PAD_W, v);
		pad_a = v[PAD_W-1:0];
		take_bits(PAD_W, v);
		pad_b = v[PAD_W-1:0];
		take_bits(PAD_W, v);
		pad_c = v[PAD_W-1:0];
		take_bits(PAD_W, v);
		pad_d = v[PAD_W-1:0];
		take_bits(PAD_W, v);
		pad_e = v[PAD_W-1:0];
	endtask

	task automatic pulse_clr();
		clr = 1'b1;
		tick(HOLD);
		clr = 1'b0;
		tick(HOLD);
	endtask

	// One sel rise, so a multitap steps once
	task automatic read_nibbles();
		sel = 1'b0;
		tick(HOLD);
		sel = 1'b1;
		tick(HOLD);
	endtask

	task automatic strobe_mouse();
		logic [15:0] v;
		take_bits(16, v);
		mouse_dx     = v[15:8];
		mouse_dy     = v[7:0];
		mouse_strobe = 1'b1;
		tick(1);
		mouse_strobe = 1'b0;
		tick(HOLD);
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		tick(16);
		check_nibble("joy_in", 4'h0, joy_in);
		check_port("port", 3'd0, u_pad_port_top.u_seq.port);
		if (u_pad_port_top.u_seq.high_bank !== 1'b0 ||
				u_pad_port_top.u_mouse.phase !== Y_LOW ||
				u_pad_port_top.u_mouse.idle_cnt !== '0 ||
				u_pad_port_top.u_mouse.acc_x !== 8'd0 ||
				u_pad_port_top.u_mouse.acc_y !== 8'd0 ||
				u_pad_port_top.u_mouse.snap_x !== 8'd0 ||
				u_pad_port_top.u_mouse.snap_y !== 8'd0) begin
			err_cnt++;
			$display("DUT state is not at its reset values at %0t", $time);
		end
		reset = 1'b0;
		tick(2);
	endtask

	// ====================
	// Test sequence
	// ====================
	initial begin
		logic [15:0] v;
		lfsr = 16'd3331;
		reset = 1'b1;
		{pad_a, pad_b, pad_c, pad_d, pad_e} = '0;
		{joy_swap, turbotap, buttons6, mouse_en, mouse_strobe} = '0;
		{mouse_dx, mouse_dy, mouse_lbtn, mouse_rbtn, sel, clr} = '0;
		apply_reset();

		// Single pad, then pads a and b swapped
		repeat (4) begin
			new_pads();
			joy_swap = 1'b0;
			pulse_clr();
			read_nibbles();
			joy_swap = 1'b1;
			read_nibbles();
		end
		joy_swap = 1'b0;

		// Multitap walk through all eight ports and the wrap
		turbotap = 1'b1;
		new_pads();
		pulse_clr();
		for (int p = 1; p <= 9; p++) begin
			read_nibbles();
			check_port("port", m_port, u_pad_port_top.u_seq.port);
		end
		turbotap = 1'b0;
		pulse_clr();
		repeat (3) read_nibbles();
		check_port("port", 3'd0, u_pad_port_top.u_seq.port);

		// Button banks, odd count leaves the high bank set
		buttons6 = 1'b1;
		repeat (5) begin
			pulse_clr();
			read_nibbles();
		end
		buttons6 = 1'b0;
		repeat (2) begin
			pulse_clr();
			read_nibbles();
		end

		// Mouse rounds of four nibbles
		mouse_en = 1'b1;
		repeat (3) begin
			new_pads();
			take_bits(2, v);
			mouse_lbtn = v[1];
			mouse_rbtn = v[0];
			strobe_mouse();
			repeat (4) begin
				pulse_clr();
				read_nibbles();
			end
		end

		// Idle past the timeout, next pulse must snapshot
		strobe_mouse();
		pulse_clr();
		tick(IDLE_LEN + 10);
		repeat (2) begin
			pulse_clr();
			read_nibbles();
		end

		apply_reset();
		assert_fails = u_pad_port_top.u_mux.u_assert.fail_cnt;
		$display("Checks %0d, errors %0d, assertion failures %0d", chk_cnt, err_cnt, assert_fails);
		if (err_cnt == 0 && assert_fails == 0 && chk_cnt > 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		wait (cycle_cnt >= CYCLE_LIMIT);
		$display("Run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/pad_port_assert.sv ====
/*
  Concurrent checks on the port counter and the read latch.
  Bound to nibble_mux, whose port input is the sequencer's counter.
  All checks are off while reset is high.
*/
`default_nettype none

module pad_port_assert import pad_pkg::*; (
	input wire logic    clk_sys,
	input wire logic    reset,
	input wire logic    sel,
	input wire logic    clr,
	input wire port_t   port,
	input wire nibble_t joy_in
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_cnt = 0;

	// clr parks the multitap on the first pad
	a_port_clr : assert property (
		@(posedge clk_sys) disable iff (reset) clr |=> (port == '0)
	) else begin
		fail_cnt++;
		$error("port is not 0 after clr was high");
	end

	a_port_hold : assert property (
		@(posedge clk_sys) disable iff (reset) (!clr && !$rose(sel)) |=> $stable(port)
	) else begin
		fail_cnt++;
		$error("port changed with no sel rise and no clr");
	end

	// Latch reads low one cycle after clr
	a_latch_clr : assert property (
		@(posedge clk_sys) disable iff (reset) clr |=> (joy_in == '0)
	) else begin
		fail_cnt++;
		$error("joy_in is not 0 one cycle after clr was high");
	end

endmodule

bind nibble_mux pad_port_assert u_assert (
	.clk_sys (clk_sys),
	.reset   (reset),
	.sel     (sel),
	.clr     (clr),
	.port    (port),
	.joy_in  (joy_in)
);

`default_nettype wire

// ==== verilog/pad_port_top.sv ====
/*
  Controller port of the console as a standalone block.
  sel and clr come straight from the console port-control lines.
  mouse_strobe is a one-cycle valid and there is no back-pressure.
  joy_in is registered, one cycle behind its inputs.
*/
`default_nettype none

module pad_port_top import pad_pkg::*; (
	input  wire logic   clk_sys,
	input  wire logic   reset,
	input  wire pad_t   pad_a,
	input  wire pad_t   pad_b,
	input  wire pad_t   pad_c,
	input  wire pad_t   pad_d,
	input  wire pad_t   pad_e,
	input  wire logic   joy_swap,
	input  wire logic   turbotap,
	input  wire logic   buttons6,
	input  wire logic   mouse_en,
	input  wire logic   mouse_strobe,
	input  wire delta_t mouse_dx,
	input  wire delta_t mouse_dy,
	input  wire logic   mouse_lbtn,
	input  wire logic   mouse_rbtn,
	input  wire logic   sel,
	input  wire logic   clr,
	output nibble_t     joy_in
);

	logic         clr_rise;
	port_t        port;
	logic         high_bank;
	mouse_phase_t phase;
	delta_t       snap_x;
	delta_t       snap_y;

	port_sequencer u_seq (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.sel       (sel),
		.clr       (clr),
		.turbotap  (turbotap),
		.buttons6  (buttons6),
		.clr_rise  (clr_rise),
		.port      (port),
		.high_bank (high_bank)
	);

	mouse_tracker u_mouse (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.clr          (clr),
		.clr_rise     (clr_rise),
		.mouse_strobe (mouse_strobe),
		.mouse_dx     (mouse_dx),
		.mouse_dy     (mouse_dy),
		.phase        (phase),
		.snap_x       (snap_x),
		.snap_y       (snap_y)
	);

	nibble_mux u_mux (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.clr        (clr),
		.sel        (sel),
		.pad_a      (pad_a),
		.pad_b      (pad_b),
		.pad_c      (pad_c),
		.pad_d      (pad_d),
		.pad_e      (pad_e),
		.joy_swap   (joy_swap),
		.mouse_en   (mouse_en),
		.mouse_lbtn (mouse_lbtn),
		.mouse_rbtn (mouse_rbtn),
		.port       (port),
		.high_bank  (high_bank),
		.phase      (phase),
		.snap_x     (snap_x),
		.snap_y     (snap_y),
		.joy_in     (joy_in)
	);

endmodule

`default_nettype wire

// ==== pad/nibble_mux.sv ====
/*
  Builds the 16-bit active-low word of the selected port and latches
  one nibble of it onto joy_in, one register stage after selection.
  Ports 5 to 7 read as an absent pad.
  Mouse mode only replaces port 0.
*/
`default_nettype none

module nibble_mux import pad_pkg::*; (
	input  wire logic         clk_sys,
	input  wire logic         reset,
	input  wire logic         clr,
	input  wire logic         sel,
	input  wire pad_t         pad_a,
	input  wire pad_t         pad_b,
	input  wire pad_t         pad_c,
	input  wire pad_t         pad_d,
	input  wire pad_t         pad_e,
	input  wire logic         joy_swap,
	input  wire logic         mouse_en,
	input  wire logic         mouse_lbtn,
	input  wire logic         mouse_rbtn,
	input  wire port_t        port,
	input  wire logic         high_bank,
	input  wire mouse_phase_t phase,
	input  wire delta_t       snap_x,
	input  wire delta_t       snap_y,
	output nibble_t           joy_in
);

	pad_t        pads [NUM_PADS];
	logic [15:0] port_word;
	nibble_t     mouse_btn;
	nibble_t     mouse_pos;
	nibble_t     nib_sel;
	nibble_idx_t nib_idx;

	// Console order of one pad, inverted since the port is active low
	function automatic logic [15:0] build_word(input pad_t p);
		logic [15:0] w;
		w[3:0]   = {p[BIT_RUN], p[BIT_SELECT], p[BIT_II], p[BIT_I]};
		w[7:4]   = {p[BIT_LEFT], p[BIT_DOWN], p[BIT_RIGHT], p[BIT_UP]};
		w[11:8]  = {p[BIT_VI], p[BIT_V], p[BIT_IV], p[BIT_III]};
		w[15:12] = 4'hF;
		return ~w;
	endfunction

	assign pads[0] = joy_swap ? pad_b : pad_a;
	assign pads[1] = joy_swap ? pad_a : pad_b;
	assign pads[2] = pad_c;
	assign pads[3] = pad_d;
	assign pads[4] = pad_e;

	// ====================
	// Mouse nibbles
	// ====================
	assign mouse_btn = ~{pads[0][BIT_RUN], pads[0][BIT_SELECT], mouse_lbtn, mouse_rbtn};

	always_comb begin
		case (phase)
			X_HIGH:  mouse_pos = snap_x[7:4];
			X_LOW:   mouse_pos = snap_x[3:0];
			Y_HIGH:  mouse_pos = snap_y[7:4];
			default: mouse_pos = snap_y[3:0];
		endcase
	end

	// ====================
	// Port word and nibble select
	// ====================
	always_comb begin
		port_word = 16'h0FFF;
		for (int i = 0; i < NUM_PADS; i++) begin
			if (int'(port) == i) begin
				port_word = build_word(pads[i]);
			end
		end
		if (port == '0 && mouse_en) begin
			port_word = {mouse_pos, mouse_btn, mouse_pos, mouse_btn};
		end
	end

	assign nib_idx = nibble_idx_t'({high_bank, sel});

	always_comb begin
		case (nib_idx)
			NIB_BUTTONS: nib_sel = port_word[3:0];
			NIB_DPAD:    nib_sel = port_word[7:4];
			NIB_EXTRA:   nib_sel = port_word[11:8];
			default:     nib_sel = port_word[15:12];
		endcase
	end

	// Read latch, forced low while clr is high
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			joy_in <= '0;
		end else if (clr) begin
			joy_in <= '0;
		end else begin
			joy_in <= nib_sel;
		end
	end

endmodule

`default_nettype wire

// ==== pad/mouse_tracker.sv ====
/*
  Mouse motion for the port-0 mouse mode.
  Deltas of the latest strobe are held until the host takes a snapshot.
  X is stored negated to match the console's axis direction.
  A long idle on clr puts the phase back at the last nibble.
*/
`default_nettype none

module mouse_tracker import pad_pkg::*; (
	input  wire logic   clk_sys,
	input  wire logic   reset,
	input  wire logic   clr,
	input  wire logic   clr_rise,
	input  wire logic   mouse_strobe,
	input  wire delta_t mouse_dx,
	input  wire delta_t mouse_dy,
	output mouse_phase_t phase,
	output delta_t      snap_x,
	output delta_t      snap_y
);

	delta_t                acc_x;
	delta_t                acc_y;
	logic [MOUSE_TO_W-1:0] idle_cnt;
	logic                  idle_full;
	logic [1:0]            phase_inc;

	assign idle_full = &idle_cnt;
	assign phase_inc = phase + 2'd1;

	// ====================
	// Inactivity timeout
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			idle_cnt <= '0;
		end else if (clr) begin
			idle_cnt <= '0;
		end else if (!idle_full) begin
			idle_cnt <= idle_cnt + 1'b1;
		end
	end

	// ====================
	// Phase, snapshot and accumulators
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			phase  <= Y_LOW;
			acc_x  <= '0;
			acc_y  <= '0;
			snap_x <= '0;
			snap_y <= '0;
		end else begin
			// Host lost track, resync on the next pulse
			if (idle_full) begin
				phase <= Y_LOW;
			end

			if (clr_rise) begin
				phase <= mouse_phase_t'(phase_inc);
				// Fourth nibble done, publish and restart
				if (phase == Y_LOW) begin
					snap_x <= acc_x;
					snap_y <= acc_y;
					acc_x  <= '0;
					acc_y  <= '0;
				end
			end

			// A fresh strobe overrides the clear above
			if (mouse_strobe) begin
				acc_x <= 8'd0 - mouse_dx;
				acc_y <= mouse_dy;
			end
		end
	end

endmodule

`default_nettype wire

// ==== pad/port_sequencer.sv ====
/*
  Tracks the console port-control lines.
  Edges are found against the value seen at the previous clock edge,
  so sel and clr must already be synchronous to clk_sys.
  The multitap index wraps from 7 to 0; ports 5 to 7 are empty.
*/
`default_nettype none

module port_sequencer import pad_pkg::*; (
	input  wire logic clk_sys,
	input  wire logic reset,
	input  wire logic sel,
	input  wire logic clr,
	input  wire logic turbotap,
	input  wire logic buttons6,
	output logic      clr_rise,
	output port_t     port,
	output logic      high_bank
);

	logic sel_d;
	logic clr_d;
	logic sel_rise;

	// ====================
	// Edge detection
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sel_d <= 1'b0;
			clr_d <= 1'b0;
		end else begin
			sel_d <= sel;
			clr_d <= clr;
		end
	end

	assign sel_rise = sel & ~sel_d;
	assign clr_rise = clr & ~clr_d;

	// ====================
	// Port counter and button bank
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			port      <= '0;
			high_bank <= 1'b0;
		end else begin
			// clr parks the multitap on the first pad
			if (clr) begin
				port <= '0;
			end else if (sel_rise && turbotap) begin
				port <= port + 1'b1;
			end

			// 6-button pads flip bank on every clr pulse
			if (clr_rise) begin
				high_bank <= ~high_bank & buttons6;
			end
		end
	end

endmodule

`default_nettype wire

// ==== common/pad_pkg.sv ====
/*
  Shared widths, pad bit layout and small types of the controller port.
  Pad words are active high, one bit per button or direction.
  Bits 8 to 11 only matter for 6-button pads.
*/
`default_nettype none

package pad_pkg;

	// ====================
	// Widths
	// ====================
	localparam int PAD_W      = 12;
	localparam int NUM_PADS   = 5;
	localparam int PORT_W     = 3;
	localparam int MOUSE_TO_W = 15;

	// ====================
	// Pad word bit layout
	// ====================
	localparam int BIT_RIGHT  = 0;
	localparam int BIT_LEFT   = 1;
	localparam int BIT_DOWN   = 2;
	localparam int BIT_UP     = 3;
	localparam int BIT_I      = 4;
	localparam int BIT_II     = 5;
	localparam int BIT_SELECT = 6;
	localparam int BIT_RUN    = 7;
	localparam int BIT_III    = 8;
	localparam int BIT_IV     = 9;
	localparam int BIT_V      = 10;
	localparam int BIT_VI     = 11;

	typedef logic [PAD_W-1:0]  pad_t;
	typedef logic [PORT_W-1:0] port_t;
	typedef logic [3:0]        nibble_t;
	typedef logic [7:0]        delta_t;

	// Order in which the host reads the mouse motion
	typedef enum logic [1:0] {
		X_HIGH = 2'd0,
		X_LOW  = 2'd1,
		Y_HIGH = 2'd2,
		Y_LOW  = 2'd3
	} mouse_phase_t;

	// Nibble index is {high_bank, sel}
	typedef enum logic [1:0] {
		NIB_BUTTONS = 2'd0,
		NIB_DPAD    = 2'd1,
		NIB_EXTRA   = 2'd2,
		NIB_ID      = 2'd3
	} nibble_idx_t;

endpackage

`default_nettype wire
